//--- tb.f
+incdir+include
design/raster_geom_pkg.sv
design/raster_cfg_pkg.sv
design/bbox_if.sv
design/bbox_extent.sv
design/bbox_clip.sv
design/bbox_vertex_delay.sv
design/bbox_top.sv
dv/bbox_scoreboard.sv
dv/bbox_tb.sv

//--- Makefile
# Verilator flow for the bounding-box stage

TOOL       ?= verilator
TOP        ?= bbox_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/bbox_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bbox_macros.svh"

module bbox_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_TESTS    = 10;
    localparam int N_TRIS       = 120;
    // Worst-case cycles per accepted triangle, stalls included
    localparam int STALL_FACTOR = 12;
    localparam int TIMEOUT_NS   = (NUM_TESTS * N_TRIS * STALL_FACTOR + 200) * CLK_PERIOD;

    // Vertex placement
    localparam int MODE_ON   = 0;
    localparam int MODE_EDGE = 1;
    localparam int MODE_OFF  = 2;
    localparam int MODE_BACK = 3;

    logic                    clk;
    logic                    rst_n;
    logic                    advance;
    logic                    in_valid;
    raster_geom_pkg::coord_t v0_x, v0_y, v1_x, v1_y, v2_x, v2_y;
    raster_geom_pkg::coord_t screen_w, screen_h;
    raster_cfg_pkg::msaa_t   msaa;
    raster_geom_pkg::coord_t out_v0_x, out_v0_y, out_v1_x, out_v1_y, out_v2_x, out_v2_y;
    raster_geom_pkg::coord_t box_ll_x, box_ll_y, box_ur_x, box_ur_y;
    logic                    out_valid;
    int                      errors;

    int pass_cnt;
    int fail_cnt;
    // Screen size in whole pixels
    int cur_w;
    int cur_h;

    logic [31:0]             lfsr_state = 32'h9daf;
    raster_geom_pkg::coord_t tri_v  [6];
    raster_geom_pkg::coord_t last_v [6];

    bbox_top i_dut (.*);

    bbox_scoreboard u_scoreboard (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, one step per bit, bits gathered MSB first
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic raster_geom_pkg::coord_t rand_coord(int lo, int hi);
        int span;
        span = hi - lo + 1;
        return raster_geom_pkg::coord_t'(lo + int'(take_bits(24) % span));
    endfunction

    // New random triangle into tri_v
    task automatic make_tri(input int mode);
        int wf, hf, mx, my, side, jump;
        wf = cur_w << `BBOX_RADIX;
        hf = cur_h << `BBOX_RADIX;
        // Edge mode spills an eighth of the screen past each side
        mx = (mode == MODE_EDGE) ? wf / 8 : 0;
        my = (mode == MODE_EDGE) ? hf / 8 : 0;
        for (int k = 0; k < `BBOX_VERTS; k++) begin
            tri_v[2*k]   = rand_coord(-mx, wf + mx);
            tri_v[2*k+1] = rand_coord(-my, hf + my);
        end
        if (mode == MODE_OFF) begin
            // Push the whole triangle one pixel past a screen edge
            side = int'(take_bits(2));
            jump = ((side < 2) ? wf : hf) + (1 << `BBOX_RADIX);
            for (int k = 0; k < `BBOX_VERTS; k++) begin
                case (side)
                    0:       tri_v[2*k]   = tri_v[2*k] + jump;
                    1:       tri_v[2*k]   = tri_v[2*k] - jump;
                    2:       tri_v[2*k+1] = tri_v[2*k+1] + jump;
                    default: tri_v[2*k+1] = tri_v[2*k+1] - jump;
                endcase
            end
        end
    endtask

    task automatic run_test(input string name, input int mode,
                            input raster_cfg_pkg::msaa_t rate, input bit stall);
        int   accepted;
        int   err_before;
        int   run_left;
        logic adv;
        @(negedge clk);
        err_before = errors;
        // Config only changes while the pipe holds bubbles
        @(posedge clk);
        cur_w    = 256 + int'(take_bits(9));
        cur_h    = 200 + int'(take_bits(8));
        in_valid <= 1'b0;
        advance  <= 1'b1;
        msaa     <= rate;
        screen_w <= raster_geom_pkg::coord_t'(cur_w << `BBOX_RADIX);
        screen_h <= raster_geom_pkg::coord_t'(cur_h << `BBOX_RADIX);
        accepted = 0;
        run_left = 0;
        adv      = 1'b1;
        while (accepted < N_TRIS) begin
            @(posedge clk);
            // Advance held in random stretches of 1 to 8 cycles
            if (stall) begin
                if (run_left == 0) begin
                    adv      = take_bits(1) != 32'd0;
                    run_left = 1 + int'(take_bits(3));
                end
                run_left--;
            end
            // Every other triangle repeats the last one with the winding reversed
            if (mode == MODE_BACK && accepted % 2 == 1)
                tri_v = '{last_v[4], last_v[5], last_v[2], last_v[3], last_v[0], last_v[1]};
            else
                make_tri(mode);
            v0_x     <= tri_v[0];
            v0_y     <= tri_v[1];
            v1_x     <= tri_v[2];
            v1_y     <= tri_v[3];
            v2_x     <= tri_v[4];
            v2_y     <= tri_v[5];
            in_valid <= take_bits(3) != 32'd0;
            advance  <= adv;
            if (adv) begin
                accepted++;
                last_v = tri_v;
            end
        end
        // Drain, the last triangle reaches the checker four edges on
        @(posedge clk);
        in_valid <= 1'b0;
        advance  <= 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (errors == err_before) begin
            pass_cnt++;
            $display("test %-16s %0d triangles, ok", name, N_TRIS);
        end else begin
            fail_cnt++;
            $display("test %-16s %0d triangles, %0d errors", name, N_TRIS, errors - err_before);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        advance  = 1'b0;
        in_valid = 1'b0;
        v0_x     = '0;
        v0_y     = '0;
        v1_x     = '0;
        v1_y     = '0;
        v2_x     = '0;
        v2_y     = '0;
        screen_w = '0;
        screen_h = '0;
        msaa     = raster_cfg_pkg::MSAA_1X;
        pass_cnt = 0;
        fail_cnt = 0;
        cur_w    = 0;
        cur_h    = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        run_test("on_screen_1x", MODE_ON, raster_cfg_pkg::MSAA_1X, 1'b0);
        run_test("on_screen_4x", MODE_ON, raster_cfg_pkg::MSAA_4X, 1'b0);
        run_test("on_screen_16x", MODE_ON, raster_cfg_pkg::MSAA_16X, 1'b0);
        run_test("on_screen_64x", MODE_ON, raster_cfg_pkg::MSAA_64X, 1'b0);
        run_test("edge_clamp", MODE_EDGE, raster_cfg_pkg::MSAA_16X, 1'b0);
        run_test("off_screen", MODE_OFF, raster_cfg_pkg::MSAA_4X, 1'b0);
        run_test("back_face", MODE_BACK, raster_cfg_pkg::MSAA_64X, 1'b0);
        run_test("stall", MODE_EDGE, raster_cfg_pkg::MSAA_4X, 1'b1);
        // Codes that are not one-hot floor like one sample per pixel
        run_test("msaa_code_0110", MODE_EDGE, raster_cfg_pkg::msaa_t'(4'b0110), 1'b0);
        run_test("msaa_code_0000", MODE_ON, raster_cfg_pkg::msaa_t'(4'b0000), 1'b0);

        $display("tests passed %0d failed %0d, mismatches %0d", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns without finishing the tests", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/bbox_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "bbox_macros.svh"

module bbox_scoreboard (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    advance,
    input  raster_geom_pkg::coord_t v0_x,
    input  raster_geom_pkg::coord_t v0_y,
    input  raster_geom_pkg::coord_t v1_x,
    input  raster_geom_pkg::coord_t v1_y,
    input  raster_geom_pkg::coord_t v2_x,
    input  raster_geom_pkg::coord_t v2_y,
    input  logic                    in_valid,
    input  raster_cfg_pkg::msaa_t   msaa,
    input  raster_geom_pkg::coord_t screen_w,
    input  raster_geom_pkg::coord_t screen_h,
    input  raster_geom_pkg::coord_t out_v0_x,
    input  raster_geom_pkg::coord_t out_v0_y,
    input  raster_geom_pkg::coord_t out_v1_x,
    input  raster_geom_pkg::coord_t out_v1_y,
    input  raster_geom_pkg::coord_t out_v2_x,
    input  raster_geom_pkg::coord_t out_v2_y,
    input  raster_geom_pkg::coord_t box_ll_x,
    input  raster_geom_pkg::coord_t box_ll_y,
    input  raster_geom_pkg::coord_t box_ur_x,
    input  raster_geom_pkg::coord_t box_ur_y,
    input  logic                    out_valid,
    output int                      errors
);

    // Three advancing edges from input to output
    localparam int DEPTH = 3;

    // Model pipe where slot DEPTH-1 holds what the outputs must show
    logic                    exp_valid [DEPTH];
    raster_geom_pkg::coord_t exp_box   [DEPTH][4];
    raster_geom_pkg::coord_t exp_v     [DEPTH][6];

    // Flattened as x0 y0 x1 y1 x2 y2 and ll_x ll_y ur_x ur_y
    raster_geom_pkg::coord_t in_v    [6];
    raster_geom_pkg::coord_t got_v   [6];
    raster_geom_pkg::coord_t got_box [4];
    raster_geom_pkg::coord_t new_box [4];
    logic                    new_valid;

    // Outputs seen on the previous edge and whether that edge held the pipe
    raster_geom_pkg::coord_t prev_v   [6];
    raster_geom_pkg::coord_t prev_box [4];
    logic                    prev_valid;
    logic                    held;
    logic                    moved;

    assign in_v    = '{v0_x, v0_y, v1_x, v1_y, v2_x, v2_y};
    assign got_v   = '{out_v0_x, out_v0_y, out_v1_x, out_v1_y, out_v2_x, out_v2_y};
    assign got_box = '{box_ll_x, box_ll_y, box_ur_x, box_ur_y};

    // Floor onto the sample grid by an arithmetic shift down and back up
    function automatic raster_geom_pkg::coord_t grid_floor(raster_geom_pkg::coord_t c,
                                                           raster_cfg_pkg::msaa_t   rate);
        int drop;
        drop = `BBOX_RADIX - int'(raster_cfg_pkg::frac_keep(rate));
        return (c >>> drop) <<< drop;
    endfunction

    // Expected box and verdict for one triangle
    task automatic predict(input  raster_geom_pkg::coord_t t [6],
                           input  logic                    vld,
                           input  raster_cfg_pkg::msaa_t   rate,
                           input  raster_geom_pkg::coord_t sw,
                           input  raster_geom_pkg::coord_t sh,
                           output logic                    keep,
                           output raster_geom_pkg::coord_t b [4]);
        raster_geom_pkg::coord_t lx, ly, hx, hy;
        raster_geom_pkg::wide_t  lhs, rhs;
        logic                    back;
        logic                    outside;
        lx = t[0];
        hx = t[0];
        ly = t[1];
        hy = t[1];
        for (int i = 1; i < `BBOX_VERTS; i++) begin
            if (t[2*i] < lx)   lx = t[2*i];
            if (t[2*i] > hx)   hx = t[2*i];
            if (t[2*i+1] < ly) ly = t[2*i+1];
            if (t[2*i+1] > hy) hy = t[2*i+1];
        end
        lx = grid_floor(lx, rate);
        ly = grid_floor(ly, rate);
        hx = grid_floor(hx, rate);
        hy = grid_floor(hy, rate);
        // Clamp to the screen where the sign bit marks a negative corner
        if (lx[`BBOX_SIGFIG-1]) lx = '0;
        if (ly[`BBOX_SIGFIG-1]) ly = '0;
        if (hx > sw) hx = sw;
        if (hy > sh) hy = sh;
        // Orientation from edges v0->v1 and v1->v2
        lhs = (raster_geom_pkg::wide_t'(t[2]) - raster_geom_pkg::wide_t'(t[0])) *
              (raster_geom_pkg::wide_t'(t[5]) - raster_geom_pkg::wide_t'(t[3]));
        rhs = (raster_geom_pkg::wide_t'(t[4]) - raster_geom_pkg::wide_t'(t[2])) *
              (raster_geom_pkg::wide_t'(t[3]) - raster_geom_pkg::wide_t'(t[1]));
        back    = lhs > rhs;
        outside = hx[`BBOX_SIGFIG-1] || hy[`BBOX_SIGFIG-1] || (lx > sw) || (ly > sh);
        keep    = vld && !back && !outside;
        b       = '{lx, ly, hx, hy};
    endtask

    task automatic check_coord(input string                   field,
                               input raster_geom_pkg::coord_t got,
                               input raster_geom_pkg::coord_t want);
        if (got !== want) begin
            $display("Fail %0t: %s got %0d expected %0d", $time, field, got, want);
            errors++;
        end
    endtask

    // Outputs seen here are the values from before this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < DEPTH; s++) begin
                exp_valid[s] = 1'b0;
                for (int f = 0; f < 4; f++)
                    exp_box[s][f] = '0;
                for (int c = 0; c < 6; c++)
                    exp_v[s][c] = '0;
            end
            held = 1'b0;
        end else begin
            // A low advance on the last edge froze every output register
            if (held) begin
                moved = out_valid !== prev_valid;
                for (int f = 0; f < 4; f++)
                    moved = moved || (got_box[f] !== prev_box[f]);
                for (int c = 0; c < 6; c++)
                    moved = moved || (got_v[c] !== prev_v[c]);
                if (moved) begin
                    $display("Fail %0t: outputs changed while advance was low", $time);
                    errors++;
                end
            end
            if (out_valid !== exp_valid[DEPTH-1]) begin
                $display("Fail %0t: out_valid got %b expected %b",
                         $time, out_valid, exp_valid[DEPTH-1]);
                errors++;
            end else if (out_valid) begin
                check_coord("box_ll_x", got_box[0], exp_box[DEPTH-1][0]);
                check_coord("box_ll_y", got_box[1], exp_box[DEPTH-1][1]);
                check_coord("box_ur_x", got_box[2], exp_box[DEPTH-1][2]);
                check_coord("box_ur_y", got_box[3], exp_box[DEPTH-1][3]);
                for (int c = 0; c < 6; c++)
                    check_coord($sformatf("out_v%0d_%s", c / 2, (c % 2) ? "y" : "x"),
                                got_v[c], exp_v[DEPTH-1][c]);
            end
            // Model moves only on edges the DUT moves on
            if (advance) begin
                for (int s = DEPTH - 1; s > 0; s--) begin
                    exp_valid[s] = exp_valid[s-1];
                    exp_box[s]   = exp_box[s-1];
                    exp_v[s]     = exp_v[s-1];
                end
                predict(in_v, in_valid, msaa, screen_w, screen_h, new_valid, new_box);
                exp_valid[0] = new_valid;
                exp_box[0]   = new_box;
                exp_v[0]     = in_v;
            end
            held       = !advance;
            prev_valid = out_valid;
            prev_box   = got_box;
            prev_v     = got_v;
        end
    end

endmodule

`default_nettype wire

//--- design/bbox_top.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Triangle in
    input  raster_geom_pkg::coord_t v0_x,
    input  raster_geom_pkg::coord_t v0_y,
    input  raster_geom_pkg::coord_t v1_x,
    input  raster_geom_pkg::coord_t v1_y,
    input  raster_geom_pkg::coord_t v2_x,
    input  raster_geom_pkg::coord_t v2_y,
    input  logic                    in_valid,

    // Low freezes the whole pipe
    input  logic                    advance,

    // Held steady while triangles flow
    input  raster_geom_pkg::coord_t screen_w,
    input  raster_geom_pkg::coord_t screen_h,
    input  raster_cfg_pkg::msaa_t   msaa,

    // Triangle and box out, three advancing edges later
    output raster_geom_pkg::coord_t out_v0_x,
    output raster_geom_pkg::coord_t out_v0_y,
    output raster_geom_pkg::coord_t out_v1_x,
    output raster_geom_pkg::coord_t out_v1_y,
    output raster_geom_pkg::coord_t out_v2_x,
    output raster_geom_pkg::coord_t out_v2_y,
    output raster_geom_pkg::coord_t box_ll_x,
    output raster_geom_pkg::coord_t box_ll_y,
    output raster_geom_pkg::coord_t box_ur_x,
    output raster_geom_pkg::coord_t box_ur_y,
    output logic                    out_valid
);

    // Snapped box between stage 2 and stage 3
    bbox_if box_bus ();

    // Stages 1 and 2
    bbox_extent u_extent (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .v0_x     (v0_x),
        .v0_y     (v0_y),
        .v1_x     (v1_x),
        .v1_y     (v1_y),
        .v2_x     (v2_x),
        .v2_y     (v2_y),
        .in_valid (in_valid),
        .msaa     (msaa),
        .box      (box_bus.src)
    );

    // Stage 3
    bbox_clip u_clip (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .box       (box_bus.dst),
        .screen_w  (screen_w),
        .screen_h  (screen_h),
        .box_ll_x  (box_ll_x),
        .box_ll_y  (box_ll_y),
        .box_ur_x  (box_ur_x),
        .box_ur_y  (box_ur_y),
        .out_valid (out_valid)
    );

    // Vertices ride alongside the box
    bbox_vertex_delay u_vdelay (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .v0_x     (v0_x),
        .v0_y     (v0_y),
        .v1_x     (v1_x),
        .v1_y     (v1_y),
        .v2_x     (v2_x),
        .v2_y     (v2_y),
        .out_v0_x (out_v0_x),
        .out_v0_y (out_v0_y),
        .out_v1_x (out_v1_x),
        .out_v1_y (out_v1_y),
        .out_v2_x (out_v2_x),
        .out_v2_y (out_v2_y)
    );

endmodule

`default_nettype wire

//--- design/bbox_vertex_delay.sv
`timescale 1ns/1ps
`default_nettype none

`include "bbox_macros.svh"

module bbox_vertex_delay (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    advance,
    input  raster_geom_pkg::coord_t v0_x,
    input  raster_geom_pkg::coord_t v0_y,
    input  raster_geom_pkg::coord_t v1_x,
    input  raster_geom_pkg::coord_t v1_y,
    input  raster_geom_pkg::coord_t v2_x,
    input  raster_geom_pkg::coord_t v2_y,
    output raster_geom_pkg::coord_t out_v0_x,
    output raster_geom_pkg::coord_t out_v0_y,
    output raster_geom_pkg::coord_t out_v1_x,
    output raster_geom_pkg::coord_t out_v1_y,
    output raster_geom_pkg::coord_t out_v2_x,
    output raster_geom_pkg::coord_t out_v2_y
);

    // Matches the two extent stages plus the clip stage
    localparam int DEPTH = 3;

    // Coordinates flattened as x0 y0 x1 y1 x2 y2
    raster_geom_pkg::coord_t din  [`BBOX_COORDS];
    raster_geom_pkg::coord_t pipe [DEPTH][`BBOX_COORDS];

    assign din = '{v0_x, v0_y, v1_x, v1_y, v2_x, v2_y};

    // Shift one slot per advancing edge, hold otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < DEPTH; s++) begin
                for (int c = 0; c < `BBOX_COORDS; c++)
                    pipe[s][c] <= '0;
            end
        end else if (advance) begin
            pipe[0] <= din;
            for (int s = 1; s < DEPTH; s++)
                pipe[s] <= pipe[s-1];
        end
    end

    assign out_v0_x = pipe[DEPTH-1][0];
    assign out_v0_y = pipe[DEPTH-1][1];
    assign out_v1_x = pipe[DEPTH-1][2];
    assign out_v1_y = pipe[DEPTH-1][3];
    assign out_v2_x = pipe[DEPTH-1][4];
    assign out_v2_y = pipe[DEPTH-1][5];

endmodule

`default_nettype wire

//--- design/bbox_clip.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_clip (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    advance,
    bbox_if.dst                     box,
    input  raster_geom_pkg::coord_t screen_w,
    input  raster_geom_pkg::coord_t screen_h,
    output raster_geom_pkg::coord_t box_ll_x,
    output raster_geom_pkg::coord_t box_ll_y,
    output raster_geom_pkg::coord_t box_ur_x,
    output raster_geom_pkg::coord_t box_ur_y,
    output logic                    out_valid
);

    // Clipped corners before the output register
    raster_geom_pkg::coord_t clip_ll_x, clip_ll_y;
    raster_geom_pkg::coord_t clip_ur_x, clip_ur_y;

    // Verdict before the output register
    logic off_screen;
    logic keep_tri;

    // Lower-left clamps at the origin
    always_comb begin
        if (box.ll_x < 0)
            clip_ll_x = '0;
        else
            clip_ll_x = box.ll_x;

        if (box.ll_y < 0)
            clip_ll_y = '0;
        else
            clip_ll_y = box.ll_y;
    end

    // Upper-right clamps at the screen edge
    always_comb begin
        if (box.ur_x > screen_w)
            clip_ur_x = screen_w;
        else
            clip_ur_x = box.ur_x;

        if (box.ur_y > screen_h)
            clip_ur_y = screen_h;
        else
            clip_ur_y = box.ur_y;
    end

    // Box left of or below the screen, or right of or above it
    assign off_screen = (clip_ur_x < 0) || (clip_ur_y < 0) ||
                        (clip_ll_x > screen_w) || (clip_ll_y > screen_h);

    // Bubbles and back faces are dropped too
    assign keep_tri = box.valid && !box.back_facing && !off_screen;

    // Stage 3 output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            box_ll_x  <= '0;
            box_ll_y  <= '0;
            box_ur_x  <= '0;
            box_ur_y  <= '0;
            out_valid <= 1'b0;
        end else if (advance) begin
            box_ll_x  <= clip_ll_x;
            box_ll_y  <= clip_ll_y;
            box_ur_x  <= clip_ur_x;
            box_ur_y  <= clip_ur_y;
            out_valid <= keep_tri;
        end
    end

endmodule

`default_nettype wire

//--- design/bbox_extent.sv
`timescale 1ns/1ps
`default_nettype none

`include "bbox_macros.svh"

module bbox_extent (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    advance,
    input  raster_geom_pkg::coord_t v0_x,
    input  raster_geom_pkg::coord_t v0_y,
    input  raster_geom_pkg::coord_t v1_x,
    input  raster_geom_pkg::coord_t v1_y,
    input  raster_geom_pkg::coord_t v2_x,
    input  raster_geom_pkg::coord_t v2_y,
    input  logic                    in_valid,
    input  raster_cfg_pkg::msaa_t   msaa,
    bbox_if.src                     box
);

    // Stage 1 vertex registers
    raster_geom_pkg::coord_t vx [`BBOX_VERTS];
    raster_geom_pkg::coord_t vy [`BBOX_VERTS];
    logic                    s1_valid;

    // Index of the extreme vertex per axis
    raster_geom_pkg::vert_idx_t lo_x, lo_y, hi_x, hi_y;

    // Edge vectors and cross terms for the winding test
    raster_geom_pkg::wide_t e01_x, e01_y, e12_x, e12_y;
    raster_geom_pkg::wide_t cross_a, cross_b;

    raster_cfg_pkg::keep_t keep;

    // Floor to the sample grid
    // Integer bits stay, only the top keep fraction bits survive
    function automatic raster_geom_pkg::coord_t snap(raster_geom_pkg::coord_t c,
                                                     raster_cfg_pkg::keep_t   k);
        raster_geom_pkg::coord_t r;
        r = c;
        for (int i = 0; i < `BBOX_RADIX; i++) begin
            if (i < `BBOX_RADIX - int'(k))
                r[i] = 1'b0;
        end
        return r;
    endfunction

    // Capture the incoming triangle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BBOX_VERTS; i++) begin
                vx[i] <= '0;
                vy[i] <= '0;
            end
            s1_valid <= 1'b0;
        end else if (advance) begin
            vx[0]    <= v0_x;
            vy[0]    <= v0_y;
            vx[1]    <= v1_x;
            vy[1]    <= v1_y;
            vx[2]    <= v2_x;
            vy[2]    <= v2_y;
            s1_valid <= in_valid;
        end
    end

    // Min/max search, ties keep the lower index
    always_comb begin
        lo_x = '0;
        lo_y = '0;
        hi_x = '0;
        hi_y = '0;
        for (int i = 1; i < `BBOX_VERTS; i++) begin
            if (vx[i] < vx[lo_x]) lo_x = raster_geom_pkg::vert_idx_t'(i);
            if (vy[i] < vy[lo_y]) lo_y = raster_geom_pkg::vert_idx_t'(i);
            if (vx[i] > vx[hi_x]) hi_x = raster_geom_pkg::vert_idx_t'(i);
            if (vy[i] > vy[hi_y]) hi_y = raster_geom_pkg::vert_idx_t'(i);
        end
    end

    // Sample pitch from the configured rate
    assign keep = raster_cfg_pkg::frac_keep(msaa);

    // Sign-extend before subtracting so no difference overflows
    assign e01_x = raster_geom_pkg::wide_t'(vx[1]) - raster_geom_pkg::wide_t'(vx[0]);
    assign e01_y = raster_geom_pkg::wide_t'(vy[1]) - raster_geom_pkg::wide_t'(vy[0]);
    assign e12_x = raster_geom_pkg::wide_t'(vx[2]) - raster_geom_pkg::wide_t'(vx[1]);
    assign e12_y = raster_geom_pkg::wide_t'(vy[2]) - raster_geom_pkg::wide_t'(vy[1]);

    assign cross_a = e01_x * e12_y;
    assign cross_b = e12_x * e01_y;

    // Stage 2, snapped box and winding into the interface
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            box.ll_x        <= '0;
            box.ll_y        <= '0;
            box.ur_x        <= '0;
            box.ur_y        <= '0;
            box.valid       <= 1'b0;
            box.back_facing <= 1'b0;
        end else if (advance) begin
            box.ll_x        <= snap(vx[lo_x], keep);
            box.ll_y        <= snap(vy[lo_y], keep);
            box.ur_x        <= snap(vx[hi_x], keep);
            box.ur_y        <= snap(vy[hi_y], keep);
            box.valid       <= s1_valid;
            box.back_facing <= cross_a > cross_b;
        end
    end

endmodule

`default_nettype wire

//--- design/bbox_if.sv
`timescale 1ns/1ps
`default_nettype none

// Snapped box handed from the extent stage to the clip stage
interface bbox_if;

    // Lower-left corner
    raster_geom_pkg::coord_t ll_x;
    raster_geom_pkg::coord_t ll_y;

    // Upper-right corner
    raster_geom_pkg::coord_t ur_x;
    raster_geom_pkg::coord_t ur_y;

    // Item is a real triangle, not a bubble
    logic valid;

    // Winding says the triangle faces away
    logic back_facing;

    // Producer side, registers live in the extent stage
    modport src (
        output ll_x, ll_y, ur_x, ur_y,
        output valid, back_facing
    );

    // Consumer side
    modport dst (
        input ll_x, ll_y, ur_x, ur_y,
        input valid, back_facing
    );

endinterface

`default_nettype wire

//--- design/raster_cfg_pkg.sv
`default_nettype none

// Configuration types for the rasterizer front end
package raster_cfg_pkg;

    // Sample rate, one-hot, same coding as the sample-test stage
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,
        MSAA_4X  = 4'b0100,
        MSAA_16X = 4'b0010,
        MSAA_64X = 4'b0001
    } msaa_t;

    // Count of fraction bits kept after the grid floor
    typedef logic [1:0] keep_t;

    // Sample pitch is 1, 1/2, 1/4 or 1/8 pixel
    // Codes that are not one-hot fall back to one sample per pixel
    function automatic keep_t frac_keep(msaa_t rate);
        case (rate)
            MSAA_4X:  return 2'd1;
            MSAA_16X: return 2'd2;
            MSAA_64X: return 2'd3;
            default:  return 2'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- design/raster_geom_pkg.sv
`default_nettype none

`include "bbox_macros.svh"

// Geometry types for the triangle bounding-box stage
package raster_geom_pkg;

    // Signed fixed-point screen coordinate
    typedef logic signed [`BBOX_SIGFIG-1:0] coord_t;

    // Product of two coordinate differences
    // Each difference needs one extra bit, the product doubles that
    typedef logic signed [2*`BBOX_SIGFIG+1:0] wide_t;

    // Index of one vertex inside a triangle
    typedef logic [$clog2(`BBOX_VERTS)-1:0] vert_idx_t;

endpackage

`default_nettype wire

//--- include/bbox_macros.svh
`ifndef BBOX_MACROS_SVH
`define BBOX_MACROS_SVH

// Fixed-point coordinate format shared by the bounding-box stage
// Integer part sits in [SIGFIG-1:RADIX], fraction in [RADIX-1:0]

// Total bits in one signed coordinate
`define BBOX_SIGFIG 24

// Fraction bits in one coordinate
`define BBOX_RADIX 10

// Vertices per triangle
`define BBOX_VERTS 3

// Coordinates per triangle, x and y for each vertex
`define BBOX_COORDS (2 * `BBOX_VERTS)

`endif
